// File: include/intr_settings.svh
// tile count and wishbone bus widths for the interrupt controller
`ifndef INTR_SETTINGS_SVH
`define INTR_SETTINGS_SVH

// number of global buffer tiles
// each tile drives store, load and pc done pulses
// twice this value has to fit in the bus data word
`define NUM_TILES 4

// wishbone data width in bits
// all accesses are full words
`define WB_DATA_WIDTH 32

// wishbone word address width
// only the lowest four word addresses are mapped
`define WB_ADDR_WIDTH 4

// field padding widths used by the data word views
`define INTR_DMA_PAD_WIDTH (`WB_DATA_WIDTH - 2 * `NUM_TILES)
`define INTR_PC_PAD_WIDTH (`WB_DATA_WIDTH - `NUM_TILES)

`endif

// File: design/wb_bus_pkg.sv
// wishbone classic request and response structs
`include "intr_settings.svh"

package wb_bus_pkg;

    // master to slave
    // adr, we and dat stay steady until ack is seen
    typedef struct packed {
        // cycle in progress
        logic                      cyc;
        // strobe, valid transfer
        logic                      stb;
        // write when high
        logic                      we;
        // word address
        logic [`WB_ADDR_WIDTH-1:0] adr;
        // write data
        logic [`WB_DATA_WIDTH-1:0] dat;
    } wb_req_t;

    // slave to master
    // ack is a single cycle strobe per transfer
    typedef struct packed {
        // transfer done
        logic                      ack;
        // read data, zero on writes
        logic [`WB_DATA_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage

// File: design/intr_reg_pkg.sv
// register address enum, register operation struct, event vector and data word union
`include "intr_settings.svh"

package intr_reg_pkg;

    // word addresses of the four registers
    // anything else decodes to ADDR_NONE
    typedef enum logic [2:0] {
        IER_DMA   = 3'd0,
        IER_PC    = 3'd1,
        ISR_DMA   = 3'd2,
        ISR_PC    = 3'd3,
        ADDR_NONE = 3'd7
    } intr_addr_e;

    // dma register layout
    // store in the low tiles, load right above
    typedef struct packed {
        logic [`INTR_DMA_PAD_WIDTH-1:0] pad;
        logic [`NUM_TILES-1:0]          load;
        logic [`NUM_TILES-1:0]          store;
    } intr_dma_word_t;

    // pc register layout, one bit per tile
    typedef struct packed {
        logic [`INTR_PC_PAD_WIDTH-1:0] pad;
        logic [`NUM_TILES-1:0]         pc;
    } intr_pc_word_t;

    // one bus data word, read as dma or as pc fields
    typedef union packed {
        intr_dma_word_t dma;
        intr_pc_word_t  pc;
    } intr_word_u;

    // full event set
    // used for pulses, enables and status alike
    typedef struct packed {
        logic [`NUM_TILES-1:0] store;
        logic [`NUM_TILES-1:0] load;
        logic [`NUM_TILES-1:0] pc;
    } intr_vec_t;

    // decoded register access, issued once per bus cycle
    typedef struct packed {
        logic       valid;
        logic       write;
        intr_addr_e addr;
        intr_word_u data;
    } reg_op_t;

endpackage

// File: design/intr_bus_decode.sv
// decode stage, wishbone cycle detection and register operation issue
`timescale 1ns/1ps

module intr_bus_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  wb_bus_pkg::wb_req_t   bus_req,
    input  wb_bus_pkg::wb_rsp_t   bus_rsp,
    output intr_reg_pkg::reg_op_t op
);

    import intr_reg_pkg::*;

    // a cycle has been issued and waits for ack
    logic       pending;
    // first sample of cyc and stb
    logic       start;
    // address mapped onto the register set
    intr_addr_e addr_dec;

    // registered op
    logic       op_valid;
    logic       op_write;
    intr_addr_e op_addr;
    intr_word_u op_data;

    // held strobe of an open cycle is not a new request
    assign start = bus_req.cyc && bus_req.stb && !pending;

    // word address to register
    always_comb begin
        case (int'(bus_req.adr))
            0:       addr_dec = IER_DMA;
            1:       addr_dec = IER_PC;
            2:       addr_dec = ISR_DMA;
            3:       addr_dec = ISR_PC;
            // unmapped, still acked
            default: addr_dec = ADDR_NONE;
        endcase
    end

    // control state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending  <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            // valid for exactly one cycle per bus cycle
            op_valid <= start;
            // ack closes the cycle
            // start cannot coincide with ack
            if (bus_rsp.ack) begin
                pending <= 1'b0;
            end else if (start) begin
                pending <= 1'b1;
            end
        end
    end

    // payload, captured with the issue strobe
    always_ff @(posedge clk) begin
        if (start) begin
            op_write <= bus_req.we;
            op_addr  <= addr_dec;
            op_data  <= bus_req.dat;
        end
    end

    assign op = '{
        valid: op_valid,
        write: op_write,
        addr:  op_addr,
        data:  op_data
    };

    // result stage only answers an issued op
    // so ack rising outside an open cycle means a broken handshake
    ack_in_cycle: assert property (
        @(posedge clk) disable iff (reset)
        $rose(bus_rsp.ack) |-> pending
    );

endmodule

// File: design/intr_status_regs.sv
// execute stage, enable and status registers with pulse capture and toggle on write
`timescale 1ns/1ps
`include "intr_settings.svh"

module intr_status_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  intr_reg_pkg::reg_op_t   op,
    input  intr_reg_pkg::intr_vec_t pulses,
    output intr_reg_pkg::intr_vec_t enables,
    output intr_reg_pkg::intr_vec_t status
);

    import intr_reg_pkg::*;

    // register write in this cycle
    logic      wr_en;
    // enabled pulses, these set status
    intr_vec_t hit;
    // toggle mask from an isr write
    intr_vec_t tgl;
    // isr write toggles cut straight from the raw word bits
    intr_vec_t raw_tgl;
    // next status value
    intr_vec_t status_nxt;

    assign wr_en = op.valid && op.write;

    // disabled pulses are dropped here
    assign hit = enables & pulses;

    // isr writes flip every bit written as one
    always_comb begin
        tgl = '0;
        if (wr_en) begin
            case (op.addr)
                ISR_DMA: begin
                    // dma view of the word
                    tgl.store = op.data.dma.store;
                    tgl.load  = op.data.dma.load;
                end
                ISR_PC: begin
                    // pc view of the word
                    tgl.pc = op.data.pc.pc;
                end
                default: begin
                    tgl = '0;
                end
            endcase
        end
    end

    // pulse wins over toggle on the same bit
    assign status_nxt = hit | (status ^ tgl);

    // enable registers
    // padding bits of the written word are dropped
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enables <= '0;
        end else if (wr_en) begin
            case (op.addr)
                IER_DMA: begin
                    enables.store <= op.data.dma.store;
                    enables.load  <= op.data.dma.load;
                end
                IER_PC: begin
                    enables.pc <= op.data.pc.pc;
                end
                default: begin
                    // isr or unmapped, enables untouched
                    enables <= enables;
                end
            endcase
        end
    end

    // status registers
    // pulses are sampled at every edge, no gating
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            status <= '0;
        end else begin
            status <= status_nxt;
        end
    end

    // store in the low tiles, load above, pc in the low tiles
    assign raw_tgl.store = (wr_en && op.addr == ISR_DMA) ? op.data[`NUM_TILES-1:0] : '0;
    assign raw_tgl.load  = (wr_en && op.addr == ISR_DMA) ?
                           op.data[2*`NUM_TILES-1:`NUM_TILES] : '0;
    assign raw_tgl.pc    = (wr_en && op.addr == ISR_PC) ? op.data[`NUM_TILES-1:0] : '0;

    // a status bit only rises after an enabled pulse
    // or an isr write carrying a one on that bit
    status_rise_cause: assert property (
        @(posedge clk) disable iff (reset)
        ((status & ~$past(status)) & ~$past((pulses & enables) | raw_tgl)) == '0
    );

endmodule

// File: design/intr_result_stage.sv
// result stage, registered read data and ack, interrupt line
`timescale 1ns/1ps

module intr_result_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  intr_reg_pkg::reg_op_t   op,
    input  intr_reg_pkg::intr_vec_t enables,
    input  intr_reg_pkg::intr_vec_t status,
    output wb_bus_pkg::wb_rsp_t     bus_rsp,
    output logic                    interrupt
);

    import intr_reg_pkg::*;

    // selected register packed into a bus word
    intr_word_u rd_word;
    // response registers
    logic       ack_q;
    intr_word_u dat_q;

    // read mux, register state before the edge
    always_comb begin
        rd_word = '0;
        case (op.addr)
            IER_DMA: begin
                rd_word.dma.store = enables.store;
                rd_word.dma.load  = enables.load;
            end
            IER_PC:  rd_word.pc.pc = enables.pc;
            ISR_DMA: begin
                rd_word.dma.store = status.store;
                rd_word.dma.load  = status.load;
            end
            ISR_PC:  rd_word.pc.pc = status.pc;
            // unmapped reads as zero
            default: rd_word = '0;
        endcase
    end

    // one ack per issued op
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= op.valid;
        end
    end

    // data only moves with an op, writes return zero
    always_ff @(posedge clk) begin
        if (op.valid) begin
            if (op.write) begin
                dat_q <= '0;
            end else begin
                dat_q <= rd_word;
            end
        end
    end

    assign bus_rsp = '{ack: ack_q, dat: dat_q};

    // level interrupt, any status bit
    assign interrupt = |status;

    // decode holds off the next op until ack is seen, so acks never abut
    ack_single: assert property (
        @(posedge clk) disable iff (reset)
        ack_q |=> !ack_q
    );

endmodule

// File: design/glb_intr_ctrl_top.sv
// top level, decode, execute and result stages of the interrupt controller
`timescale 1ns/1ps

module glb_intr_ctrl_top (
    input  logic                    clk,
    input  logic                    reset,
    input  wb_bus_pkg::wb_req_t     bus_req,
    input  intr_reg_pkg::intr_vec_t pulses,
    output wb_bus_pkg::wb_rsp_t     bus_rsp,
    output logic                    interrupt
);

    import intr_reg_pkg::*;

    // decode to execute and result
    reg_op_t   op;
    // execute to result
    intr_vec_t enables;
    intr_vec_t status;

    // bus cycle to register op
    // response fed back to close the cycle
    intr_bus_decode i_intr_bus_decode (
        .clk     (clk),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .op      (op)
    );

    // enable and status state
    intr_status_regs i_intr_status_regs (
        .clk     (clk),
        .reset   (reset),
        .op      (op),
        .pulses  (pulses),
        .enables (enables),
        .status  (status)
    );

    // ack, read data and interrupt line
    intr_result_stage i_intr_result_stage (
        .clk       (clk),
        .reset     (reset),
        .op        (op),
        .enables   (enables),
        .status    (status),
        .bus_rsp   (bus_rsp),
        .interrupt (interrupt)
    );

endmodule

// File: verification/tb_glb_intr_ctrl.sv
// testbench for the interrupt controller top level, stimulus table, reference model, watchdog
`timescale 1ns/1ps
`include "intr_settings.svh"

module tb_glb_intr_ctrl;

    import wb_bus_pkg::*;
    import intr_reg_pkg::*;

    localparam int N            = `NUM_TILES;
    localparam int MAX_ROWS     = 64;
    localparam int RANDOM_STEPS = 24;
    localparam int ACK_LIMIT    = 16;
    // row kinds
    localparam int K_WRITE = 0;
    localparam int K_READ  = 1;
    localparam int K_PULSE = 2;
    // register field masks
    localparam logic [31:0] PC_MASK  = (32'd1 << N) - 32'd1;
    localparam logic [31:0] DMA_MASK = (32'd1 << (2 * N)) - 32'd1;

    logic      clk = 1'b0;
    logic      reset;
    wb_req_t   bus_req;
    wb_rsp_t   bus_rsp;
    intr_vec_t pulses;
    logic      interrupt;

    // stimulus table
    string       row_name  [MAX_ROWS];
    int          row_kind  [MAX_ROWS];
    logic [3:0]  row_addr  [MAX_ROWS];
    logic [31:0] row_data  [MAX_ROWS];
    // pulses of a pulse row, or pulses held across a write
    intr_vec_t   row_pulse [MAX_ROWS];
    // read value, zero for writes, interrupt level for pulses
    logic [31:0] row_exp   [MAX_ROWS];
    int          num_rows = 0;
    logic        table_ready = 1'b0;

    // reference model, kept in bus word form
    logic [31:0] m_en_dma = '0;
    logic [31:0] m_en_pc  = '0;
    logic [31:0] m_st_dma = '0;
    logic [31:0] m_st_pc  = '0;

    logic [31:0] rng_state = 32'd63;
    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic        test_failed;

    glb_intr_ctrl_top i_glb_intr_ctrl_top (
        .clk       (clk),
        .reset     (reset),
        .bus_req   (bus_req),
        .pulses    (pulses),
        .bus_rsp   (bus_rsp),
        .interrupt (interrupt)
    );

    always #5 clk = ~clk;

    // lcg, numerical recipes constants
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // store field low, load field right above
    function automatic logic [31:0] dma_word(input logic [31:0] store, input logic [31:0] load);
        return ((load & PC_MASK) << N) | (store & PC_MASK);
    endfunction

    function automatic intr_vec_t make_vec(input logic [31:0] store, input logic [31:0] load,
                                           input logic [31:0] pc);
        intr_vec_t v;
        v.store = store[N-1:0];
        v.load  = load[N-1:0];
        v.pc    = pc[N-1:0];
        return v;
    endfunction

    task automatic add_row(input string name, input int kind, input logic [3:0] addr,
                           input logic [31:0] data, input intr_vec_t p, input logic [31:0] exp);
        row_name[num_rows]  = name;
        row_kind[num_rows]  = kind;
        row_addr[num_rows]  = addr;
        row_data[num_rows]  = data;
        row_pulse[num_rows] = p;
        row_exp[num_rows]   = exp;
        num_rows++;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s: expected 0x%08h actual 0x%08h", name, exp, act);
            errors++;
            test_failed = 1'b1;
        end
    endtask

    // register writes as software sees them
    task automatic model_write(input logic [3:0] adr, input logic [31:0] dat);
        case (adr)
            4'd0:    m_en_dma = dat & DMA_MASK;
            4'd1:    m_en_pc  = dat & PC_MASK;
            4'd2:    m_st_dma = m_st_dma ^ (dat & DMA_MASK);
            4'd3:    m_st_pc  = m_st_pc ^ (dat & PC_MASK);
            default: ;
        endcase
    endtask

    // enabled pulses set status, applied after any toggle
    task automatic model_pulse(input intr_vec_t p);
        m_st_dma = m_st_dma | (m_en_dma & dma_word(32'(p.store), 32'(p.load)));
        m_st_pc  = m_st_pc | (m_en_pc & 32'(p.pc));
    endtask

    // one wishbone classic cycle, pulses held until the write has landed
    task automatic bus_access(input string name, input logic we, input logic [3:0] adr,
                              input logic [31:0] dat, input intr_vec_t hold,
                              output logic [31:0] rdat);
        int   waited;
        logic got;
        @(posedge clk);
        bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        pulses  <= hold;
        waited = 0;
        got    = 1'b0;
        rdat   = '0;
        // ack sampled mid cycle
        while (!got && waited < ACK_LIMIT) begin
            @(posedge clk);
            // a write lands at the second edge, no pulse after it
            if (waited == 1) begin
                pulses <= '0;
            end
            @(negedge clk);
            if (bus_rsp.ack) begin
                got  = 1'b1;
                rdat = bus_rsp.dat;
            end
            waited++;
        end
        if (!got) begin
            $display("no ack from the DUT within %0d cycles in %s", ACK_LIMIT, name);
            errors++;
            test_failed = 1'b1;
        end
        // stb drops in the cycle after ack
        @(posedge clk);
        bus_req <= '0;
        pulses  <= '0;
    endtask

    task automatic do_write(input string name, input logic [3:0] adr, input logic [31:0] dat,
                            input intr_vec_t hold);
        logic [31:0] rd;
        bus_access(name, 1'b1, adr, dat, hold, rd);
        model_write(adr, dat);
        model_pulse(hold);
        // write ack carries zero data
        check(name, 32'd0, rd);
    endtask

    task automatic do_read(input string name, input logic [3:0] adr, input logic [31:0] exp);
        logic [31:0] rd;
        bus_access(name, 1'b0, adr, 32'd0, '0, rd);
        check(name, exp, rd);
    endtask

    // single cycle pulse, interrupt sampled after capture
    task automatic pulse_once(input intr_vec_t p);
        @(posedge clk);
        pulses <= p;
        @(posedge clk);
        pulses <= '0;
        @(negedge clk);
        model_pulse(p);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_failed) begin
            tests_failed++;
        end
        $display("test %s done, %s", name, test_failed ? "mismatch" : "ok");
    endtask

    task automatic build_table();
        intr_vec_t all_ones;
        intr_vec_t none;
        all_ones = make_vec(PC_MASK, PC_MASK, PC_MASK);
        none     = '0;
        // reset values, disabled pulses
        add_row("rd_reset_ier_dma", K_READ, 4'd0, 32'd0, none, 32'd0);
        add_row("rd_reset_ier_pc", K_READ, 4'd1, 32'd0, none, 32'd0);
        add_row("rd_reset_isr_dma", K_READ, 4'd2, 32'd0, none, 32'd0);
        add_row("rd_reset_isr_pc", K_READ, 4'd3, 32'd0, none, 32'd0);
        add_row("pulse_all_disabled", K_PULSE, 4'd0, 32'd0, all_ones, 32'd0);
        add_row("rd_isr_dma_disabled", K_READ, 4'd2, 32'd0, none, 32'd0);
        add_row("rd_isr_pc_disabled", K_READ, 4'd3, 32'd0, none, 32'd0);
        // enable read back and masking
        add_row("wr_ier_dma_ones", K_WRITE, 4'd0, 32'hffff_ffff, none, 32'd0);
        add_row("rd_ier_dma_masked", K_READ, 4'd0, 32'd0, none, DMA_MASK);
        add_row("wr_ier_pc_ones", K_WRITE, 4'd1, 32'hffff_ffff, none, 32'd0);
        add_row("rd_ier_pc_masked", K_READ, 4'd1, 32'd0, none, PC_MASK);
        // unmapped address, zeros would clear an aliased enable
        add_row("wr_unmapped", K_WRITE, 4'd5, 32'd0, none, 32'd0);
        add_row("rd_unmapped", K_READ, 4'd5, 32'd0, none, 32'd0);
        add_row("rd_ier_dma_kept", K_READ, 4'd0, 32'd0, none, DMA_MASK);
        add_row("rd_ier_pc_kept", K_READ, 4'd1, 32'd0, none, PC_MASK);
        add_row("wr_ier_dma_part", K_WRITE, 4'd0, dma_word(5, 3), none, 32'd0);
        add_row("rd_ier_dma_part", K_READ, 4'd0, 32'd0, none, dma_word(5, 3));
        add_row("wr_ier_pc_part", K_WRITE, 4'd1, 32'd6, none, 32'd0);
        add_row("rd_ier_pc_part", K_READ, 4'd1, 32'd0, none, 32'd6 & PC_MASK);
        // capture through the enables only
        add_row("pulse_all_enabled", K_PULSE, 4'd0, 32'd0, all_ones, 32'd1);
        add_row("rd_isr_dma_captured", K_READ, 4'd2, 32'd0, none, dma_word(5, 3));
        add_row("rd_isr_pc_captured", K_READ, 4'd3, 32'd0, none, 32'd6 & PC_MASK);
        add_row("pulse_disabled_store", K_PULSE, 4'd0, 32'd0, make_vec(32'ha, 0, 0), 32'd1);
        add_row("rd_isr_dma_unchanged", K_READ, 4'd2, 32'd0, none, dma_word(5, 3));
        // toggle on write
        add_row("tgl_isr_dma_clear", K_WRITE, 4'd2, dma_word(5, 3), none, 32'd0);
        add_row("rd_isr_dma_cleared", K_READ, 4'd2, 32'd0, none, 32'd0);
        add_row("tgl_isr_pc_clear", K_WRITE, 4'd3, 32'd6, none, 32'd0);
        add_row("rd_isr_pc_cleared", K_READ, 4'd3, 32'd0, none, 32'd0);
        add_row("irq_dropped", K_PULSE, 4'd0, 32'd0, none, 32'd0);
        add_row("tgl_isr_pc_set", K_WRITE, 4'd3, 32'd1, none, 32'd0);
        add_row("rd_isr_pc_set", K_READ, 4'd3, 32'd0, none, 32'd1);
        add_row("irq_from_toggle", K_PULSE, 4'd0, 32'd0, none, 32'd1);
        add_row("tgl_isr_pc_reclear", K_WRITE, 4'd3, 32'd1, none, 32'd0);
        add_row("rd_isr_pc_reclear", K_READ, 4'd3, 32'd0, none, 32'd0);
        // pulse held across a toggle of the same bit
        add_row("pulse_pc_bit1", K_PULSE, 4'd0, 32'd0, make_vec(0, 0, 2), 32'd1);
        add_row("tgl_under_pulse", K_WRITE, 4'd3, 32'd2, make_vec(0, 0, 2), 32'd0);
        add_row("rd_pulse_wins", K_READ, 4'd3, 32'd0, none, 32'd2);
        add_row("tgl_after_pulse", K_WRITE, 4'd3, 32'd2, none, 32'd0);
        add_row("rd_pulse_gone", K_READ, 4'd3, 32'd0, none, 32'd0);
        add_row("irq_final", K_PULSE, 4'd0, 32'd0, none, 32'd0);
    endtask

    // random enables, pulses and toggles against the model
    task automatic random_step(input int step);
        string       name;
        logic [31:0] r;
        intr_vec_t   p;
        name = $sformatf("random_%0d", step);
        r = next_rand();
        if (r[17:16] == 2'd0) begin
            do_write(name, 4'd0, next_rand() >> 12, '0);
        end else if (r[17:16] == 2'd1) begin
            do_write(name, 4'd1, next_rand() >> 12, '0);
        end
        p = make_vec(next_rand() >> 16, next_rand() >> 16, next_rand() >> 16);
        pulse_once(p);
        if (r[18]) begin
            do_write(name, 4'd2, next_rand() >> 12, '0);
        end
        if (r[19]) begin
            do_write(name, 4'd3, next_rand() >> 12, '0);
        end
        do_read(name, 4'd2, m_st_dma);
        do_read(name, 4'd3, m_st_pc);
        @(negedge clk);
        check(name, ((m_st_dma | m_st_pc) != 32'd0) ? 32'd1 : 32'd0, 32'(interrupt));
    endtask

    // bound scales with the amount of stimulus
    initial begin
        wait (table_ready);
        repeat ((num_rows + RANDOM_STEPS) * 20) @(posedge clk);
        $display("watchdog timeout, tests did not finish in %0d cycles",
                 (num_rows + RANDOM_STEPS) * 20);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        reset   = 1'b1;
        bus_req = '0;
        pulses  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < num_rows; i++) begin
            test_failed = 1'b0;
            case (row_kind[i])
                K_WRITE: do_write(row_name[i], row_addr[i], row_data[i], row_pulse[i]);
                K_READ:  do_read(row_name[i], row_addr[i], row_exp[i]);
                default: begin
                    pulse_once(row_pulse[i]);
                    check(row_name[i], row_exp[i], 32'(interrupt));
                end
            endcase
            finish_test(row_name[i]);
        end
        for (int s = 0; s < RANDOM_STEPS; s++) begin
            test_failed = 1'b0;
            random_step(s);
            finish_test($sformatf("random_%0d", s));
        end
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
design/wb_bus_pkg.sv
design/intr_reg_pkg.sv
design/intr_bus_decode.sv
design/intr_status_regs.sv
design/intr_result_stage.sv
design/glb_intr_ctrl_top.sv
verification/tb_glb_intr_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the interrupt controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_glb_intr_ctrl

out=$(./obj_dir/Vtb_glb_intr_ctrl)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "PASS: all tests"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
